// File: src/ipv4_pkg.sv
/* IPv4 checksum verify
   Shared types and constants */

package ipv4_pkg;

    // ####################
    // Header geometry
    // ####################

    localparam int hdr_bits      = 160; // Option-less IPv4 header
    localparam int hdr_words     = 10;  // 16-bit words per header
    localparam int csum_word_idx = 4;   // Checksum word, counted from the LSB end

    // Format check values
    localparam logic [3:0] ip_version_v4 = 4'd4;
    localparam logic [3:0] ip_ihl_min    = 4'd5; // Five 32-bit words, no options

    localparam int pipe_latency = 3; // Input valid to result valid, in cycles

    // ####################
    // Header views
    // ####################

    // Field layout, MSB first as on the wire
    typedef struct packed {
        logic [3:0]  version;         // [159:156]
        logic [3:0]  ihl;             // [155:152]
        logic [5:0]  dscp;            // [151:146]
        logic [1:0]  ecn;             // [145:144]
        logic [15:0] length;          // [143:128]
        logic [15:0] identification;  // [127:112]
        logic [2:0]  flags;           // [111:109]
        logic [12:0] fragment_offset; // [108:96]
        logic [7:0]  ttl;             // [95:88]
        logic [7:0]  protocol;        // [87:80]
        logic [15:0] hdr_chksum;      // [79:64]
        logic [31:0] source_ip;       // [63:32]
        logic [31:0] dest_ip;         // [31:0]
    } ipv4_fields_t;

    // Same header read as fields or as the words that get summed
    typedef union packed {
        ipv4_fields_t                                  fields;
        logic [hdr_words-1:0][hdr_bits/hdr_words-1:0] words; // words[0] is bits [15:0]
    } ipv4_header_u;

    // ####################
    // Stream and stages
    // ####################

    // Input beat, no ready
    typedef struct packed {
        logic         valid;
        ipv4_header_u header;
    } hdr_beat_t;

    // Stage 1 to stage 2
    typedef struct packed {
        logic        valid;
        logic [19:0] raw_sum;   // Nine words, carries not yet folded
        logic [15:0] rx_chksum; // Checksum as received
        logic        format_ok; // Version 4 and IHL 5
    } sum_stage_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic        valid;
        logic [15:0] computed;  // Complement of the folded sum
        logic [15:0] rx_chksum;
        logic        format_ok;
    } fold_stage_t;

    // Result beat
    typedef struct packed {
        logic        valid;
        logic        checksum_ok; // Computed matches received
        logic        format_ok;
        logic [15:0] computed;
    } verify_result_t;

endpackage

// File: src/ipv4_header_sum.sv
/* IPv4 checksum stage 1
   Header word sum */

module ipv4_header_sum (
    input  logic                  ipv4_header, // Clock
    input  logic                  rst_n,
    input  ipv4_pkg::hdr_beat_t   hdr_in,
    output ipv4_pkg::sum_stage_t  s1
);

    // ####################
    // Word sum
    // ####################

    logic [19:0] raw_sum;   // 9 x 0xFFFF fits in 20 bits
    logic [15:0] rx_chksum;
    logic        format_ok;

    // Plain sum over the words view, checksum word left out
    always_comb begin
        raw_sum = '0;
        for (int i = 0; i < ipv4_pkg::hdr_words; i++) begin
            if (i != ipv4_pkg::csum_word_idx) begin
                raw_sum = raw_sum + 20'(hdr_in.header.words[i]);
            end
        end
    end

    // Fields view of the same header
    assign rx_chksum = hdr_in.header.fields.hdr_chksum;

    // Only option-less v4 headers pass
    assign format_ok = (hdr_in.header.fields.version == ipv4_pkg::ip_version_v4) &&
                       (hdr_in.header.fields.ihl == ipv4_pkg::ip_ihl_min);

    // ####################
    // Stage register
    // ####################

    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            s1.valid <= 1'b0;
        end else begin
            s1.valid <= hdr_in.valid;
        end
        // Payload follows every cycle, qualified by valid downstream
        s1.raw_sum   <= raw_sum;
        s1.rx_chksum <= rx_chksum;
        s1.format_ok <= format_ok;
    end

endmodule

// File: src/ipv4_checksum_fold.sv
/* IPv4 checksum stage 2
   Carry fold and complement */

module ipv4_checksum_fold (
    input  logic                   ipv4_header, // Clock
    input  logic                   rst_n,
    input  ipv4_pkg::sum_stage_t   s1,
    output ipv4_pkg::fold_stage_t  s2
);

    logic [16:0] fold1;    // Low word plus upper nibble, may carry once more
    logic [15:0] fold2;    // Second fold, no carry left
    logic [15:0] computed;

    // ####################
    // End-around carry
    // ####################

    // First fold, max 0xFFFF + 0xF
    assign fold1 = {1'b0, s1.raw_sum[15:0]} + 17'(s1.raw_sum[19:16]);

    // When fold1 carries its low word is tiny, so this never overflows
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    assign computed = ~fold2; // One's-complement checksum

    // ####################
    // Stage register
    // ####################

    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            s2.valid <= 1'b0;
        end else begin
            s2.valid <= s1.valid;
        end
        s2.computed  <= computed;
        s2.rx_chksum <= s1.rx_chksum;  // Carried along for stage 3
        s2.format_ok <= s1.format_ok;
    end

endmodule

// File: src/ipv4_checksum_compare.sv
/* IPv4 checksum stage 3
   Checksum compare */

module ipv4_checksum_compare (
    input  logic                     ipv4_header, // Clock
    input  logic                     rst_n,
    input  ipv4_pkg::fold_stage_t    s2,
    output ipv4_pkg::verify_result_t result
);

    logic checksum_ok;

    // Computed against received
    assign checksum_ok = (s2.computed == s2.rx_chksum);

    // ####################
    // Result register
    // ####################

    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s2.valid;
        end
        result.checksum_ok <= checksum_ok;
        result.format_ok   <= s2.format_ok; // Independent of the checksum match
        result.computed    <= s2.computed;  // Reported for debug and logging
    end

endmodule

// File: src/ipv4_checksum_verify.sv
/* IPv4 checksum verify
   Three-stage pipeline top */

module ipv4_checksum_verify (
    input  logic                     ipv4_header, // Clock
    input  logic                     rst_n,
    input  ipv4_pkg::hdr_beat_t      hdr_in,      // Valid-only stream, always accepted
    output ipv4_pkg::verify_result_t result       // Three cycles after hdr_in
);

    // ####################
    // Stage links
    // ####################

    ipv4_pkg::sum_stage_t  s1; // Raw sum, received checksum, format
    ipv4_pkg::fold_stage_t s2; // Computed checksum, received checksum, format

    // Stage 1, word sum and field extraction
    ipv4_header_sum u_ipv4_header_sum (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .s1          (s1)
    );

    // Stage 2, fold and complement
    ipv4_checksum_fold u_ipv4_checksum_fold (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .s1          (s1),
        .s2          (s2)
    );

    // Stage 3, compare and output
    ipv4_checksum_compare u_ipv4_checksum_compare (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .s2          (s2),
        .result      (result)
    );

endmodule

// File: verification/ipv4_checksum_verify_asserts.sv
/* IPv4 checksum pipeline checks */

module ipv4_checksum_verify_asserts (
    input logic                     ipv4_header, // Clock
    input logic                     rst_n,
    input ipv4_pkg::hdr_beat_t      hdr_in,
    input ipv4_pkg::verify_result_t result
);

    // ####################
    // Timing
    // ####################

    // Fixed latency, one result per input beat
    property p_latency;
        @(posedge ipv4_header) disable iff (!rst_n)
            result.valid == $past(hdr_in.valid, ipv4_pkg::pipe_latency);
    endproperty

    a_latency: assert property (p_latency)
        else $error("result.valid does not follow hdr_in.valid by the pipeline latency");

    // Sync reset clears the output valid one edge later
    a_reset_clears: assert property (@(posedge ipv4_header) !rst_n |=> !result.valid)
        else $error("result.valid high in the cycle after reset");

    // ####################
    // Data
    // ####################

    a_computed_known: assert property (@(posedge ipv4_header) disable iff (!rst_n)
            result.valid |-> !$isunknown(result.computed))
        else $error("result.computed unknown while result.valid is high");

endmodule

// File: verification/ipv4_checksum_verify_tb.sv
/* IPv4 checksum verify testbench */

module ipv4_checksum_verify_tb;

    localparam int    clk_period    = 8;
    localparam int    reset_cycles  = 8;
    localparam int    margin_cycles = 32;  // Post-reset idle, drain and slack
    localparam int    max_lines     = 64;
    localparam string stim_path     = "verification/ipv4_checksum_stim.txt";

    logic                     ipv4_header; // Clock
    logic                     rst_n;
    ipv4_pkg::hdr_beat_t      hdr_in;
    ipv4_pkg::verify_result_t result;

    // Stimulus table, filled once from the data file
    logic [ipv4_pkg::hdr_bits-1:0] hdr_mem [max_lines];
    ipv4_pkg::verify_result_t      exp_mem [max_lines];
    int                            num_lines;
    logic                          stim_loaded;

    ipv4_pkg::verify_result_t expected_q[$]; // Headers in flight, oldest first
    ipv4_pkg::verify_result_t exp_res;
    logic [16:0]              lfsr;          // Idle gap source

    ipv4_checksum_verify u_ipv4_checksum_verify (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .result      (result)
    );

    bind ipv4_checksum_verify ipv4_checksum_verify_asserts u_ipv4_checksum_verify_asserts (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .result      (result)
    );

    initial begin
        ipv4_header = 1'b0;
        forever #(clk_period / 2) ipv4_header = ~ipv4_header;
    end

    // ####################
    // Helpers
    // ####################

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // x^17 + x^14 + 1, one step per bit
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    task automatic next_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            gap  = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_result(input string name, input ipv4_pkg::verify_result_t got,
                                input ipv4_pkg::verify_result_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ####################
    // Stimulus file
    // ####################

    task automatic load_stimulus();
        int                            fd;
        int                            code;
        int                            got;
        string                         line;
        logic [ipv4_pkg::hdr_bits-1:0] hdr_v;
        logic                          ok_bit;
        logic                          fmt_bit;
        logic [15:0]                   csum;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            stop_on_error({"cannot open stimulus file ", stim_path});
        end
        num_lines = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() <= 2 || line[0] == "#") continue; // Blank or column notes
            got = $sscanf(line, "%h %b %b %h", hdr_v, ok_bit, fmt_bit, csum);
            if (got != 4) begin
                stop_on_error($sformatf("malformed stimulus line: %s", line));
            end
            if (num_lines == max_lines) begin
                stop_on_error("stimulus file has more lines than the table holds");
            end
            hdr_mem[num_lines] = hdr_v;
            exp_mem[num_lines] = '{valid: 1'b1, checksum_ok: ok_bit,
                                   format_ok: fmt_bit, computed: csum};
            num_lines++;
        end
        $fclose(fd);
        if (num_lines == 0) begin
            stop_on_error("stimulus file holds no headers");
        end
    endtask

    // One beat, expected result queued in the same cycle
    task automatic send_header(input int idx);
        hdr_in.valid  = 1'b1;
        hdr_in.header = hdr_mem[idx];
        expected_q.push_back(exp_mem[idx]);
        @(negedge ipv4_header);
    endtask

    task automatic idle_cycles(input int n);
        hdr_in.valid = 1'b0;
        repeat (n) @(negedge ipv4_header);
    endtask

    // ####################
    // Driver
    // ####################

    initial begin : driver
        int gap;
        rst_n       = 1'b0;
        hdr_in      = '0;
        lfsr        = 17'd86230;
        stim_loaded = 1'b0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (reset_cycles) @(negedge ipv4_header);
        rst_n = 1'b1;
        idle_cycles(3); // Nothing sent, so the monitor must stay quiet
        // Pass 0 with random gaps, pass 1 fully back to back
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < num_lines; i++) begin
                send_header(i);
                if (pass == 0) begin
                    next_gap(gap);
                end else begin
                    gap = 0;
                end
                idle_cycles(gap);
            end
        end
        idle_cycles(ipv4_pkg::pipe_latency + 2); // Drain the pipe
        if (expected_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected results never arrived",
                                    expected_q.size()));
        end
    end

    // ####################
    // Monitor
    // ####################

    always @(posedge ipv4_header) begin
        if (rst_n && result.valid) begin
            if (expected_q.size() == 0) begin
                stop_on_error("result valid seen with no header outstanding");
            end else begin
                exp_res = expected_q.pop_front();
                check_flag("result.checksum_ok", result.checksum_ok, exp_res.checksum_ok);
                check_flag("result.format_ok", result.format_ok, exp_res.format_ok);
                check_result("result", result, exp_res); // Catches computed too
            end
        end
    end

    // Limit from table size, both passes stay under 8 cycles per line
    initial begin : watchdog
        int limit_cycles;
        wait (stim_loaded);
        limit_cycles = num_lines * 8 + reset_cycles + margin_cycles;
        repeat (limit_cycles) @(posedge ipv4_header);
        stop_on_error($sformatf("watchdog timeout after %0d cycles", limit_cycles));
    end

endmodule

// File: verification/ipv4_checksum_stim.txt
# header (40 hex digits, MSB first) expected_checksum_ok expected_format_ok
# expected_computed_checksum (hex)
45000073000040004011b861c0a80001c0a800c7 1 1 b861
4500003c1c4640004006b1e6ac100a63ac100a0c 1 1 b1e6
45000054a6f2400040017fb40a0000010a000002 1 1 7fb4
4500001c000100004001f78cc0a80101c0a80102 1 1 f78c
45000073000040004011b862c0a80001c0a800c7 0 1 b861
4500003c1c46400040060000ac100a63ac100a0c 0 1 b1e6
45000054a6f2400040017fb50a0000010a000002 0 1 7fb4
650000730000400040119861c0a80001c0a800c7 1 0 9861
46000073000040004011b861c0a80001c0a800c7 0 0 b761
44000073000040004011b961c0a80001c0a800c7 1 0 b961
5500001c000100004001f78cc0a80101c0a80102 0 0 e78c
4500ffffffffbb010000fffd0000000000000000 1 1 fffd
4500ffffffffffffffffbaffffffffffffffffff 1 1 baff
4500fffefffdfffcfffbbb23fffafff9fff8fff7 1 1 bb23
ffffffffffffffffffff0000ffffffffffffffff 1 0 0000
0000000000000000000000000000000000000000 0 0 ffff
00000000000000000000ffff0000000000000000 1 0 ffff

// File: verilog.f
src/ipv4_pkg.sv
src/ipv4_header_sum.sv
src/ipv4_checksum_fold.sv
src/ipv4_checksum_compare.sv
src/ipv4_checksum_verify.sv
verification/ipv4_checksum_verify_asserts.sv
verification/ipv4_checksum_verify_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IPv4 checksum testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ipv4_checksum_verify_tb \
    -Mdir obj_dir \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vipv4_checksum_verify_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished"
exit 0
